// ==== rtl/apb_pkg.sv ====
package apb_pkg;

    localparam int APB_AW = 32;
    localparam int APB_DW = 32;

    // request from the master
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic [APB_AW-1:0]     paddr;
        logic                  pwrite;
        logic [APB_DW/8-1:0]   pstrb;
        logic [APB_DW-1:0]     pwdata;
    } apb_req_t;

    // response from a slave
    typedef struct packed {
        logic [APB_DW-1:0]     prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // byte lanes of wdata replace the current value where strb is set
    function automatic logic [APB_DW-1:0] apply_strb(
        input logic [APB_DW-1:0]   cur,
        input logic [APB_DW-1:0]   wdata,
        input logic [APB_DW/8-1:0] strb
    );
        logic [APB_DW-1:0] res;
        res = cur;
        for (int i = 0; i < APB_DW / 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/sysctl_pkg.sv ====
package sysctl_pkg;

    localparam int XLEN   = 32;
    localparam int TIME_W = 64;

    // address bit 12 picks the slave, bits above it must be zero
    localparam int REGION_BIT = 12;

    // cfgreg offsets
    localparam logic [REGION_BIT-1:0] CFG_DDR_OFFSET   = 12'h000;
    localparam logic [REGION_BIT-1:0] CFG_BOOTVEC      = 12'h004;
    localparam logic [REGION_BIT-1:0] CFG_CORE_RST     = 12'h008;

    // intc offsets
    localparam logic [REGION_BIT-1:0] INTC_MSIP        = 12'h000;
    localparam logic [REGION_BIT-1:0] INTC_MTIMECMP_LO = 12'h008;
    localparam logic [REGION_BIT-1:0] INTC_MTIMECMP_HI = 12'h00C;
    localparam logic [REGION_BIT-1:0] INTC_MTIME_LO    = 12'h010;
    localparam logic [REGION_BIT-1:0] INTC_MTIME_HI    = 12'h014;
    localparam logic [REGION_BIT-1:0] INTC_IE          = 12'h018;
    localparam logic [REGION_BIT-1:0] INTC_IP          = 12'h01C;

    // register values after reset
    localparam logic [XLEN-1:0]   DDR_OFFSET_INIT = '0;
    localparam logic              CORE_RSTN_INIT  = 1'b1;
    // all ones keeps the timer interrupt quiet until software arms it
    localparam logic [TIME_W-1:0] MTIMECMP_INIT   = '1;

    // interrupt lines towards the core
    typedef struct packed {
        logic msip;
        logic mtip;
        logic meip;
    } irq_t;

endpackage

// ==== rtl/apb_split.sv ====
`timescale 1ns/1ps

module apb_split import apb_pkg::*, sysctl_pkg::*; (
    input  apb_req_t req,
    output apb_rsp_t rsp,
    output apb_req_t cfg_req,
    input  apb_rsp_t cfg_rsp,
    output apb_req_t intc_req,
    input  apb_rsp_t intc_rsp
);

    logic in_map;
    logic to_intc;
    logic access;

    // anything with upper address bits set belongs to no slave
    assign in_map  = (req.paddr[APB_AW-1:REGION_BIT+1] == '0);
    assign to_intc = req.paddr[REGION_BIT];
    assign access  = req.psel & req.penable;

    // only the addressed slave sees psel
    always_comb begin
        cfg_req       = req;
        intc_req      = req;
        cfg_req.psel  = req.psel & in_map & ~to_intc;
        intc_req.psel = req.psel & in_map & to_intc;
    end

    always_comb begin
        if (!in_map) begin
            // out of map, answered here with an error
            rsp.prdata  = '0;
            rsp.pready  = access;
            rsp.pslverr = access;
        end else if (to_intc) begin
            rsp = intc_rsp;
        end else begin
            rsp = cfg_rsp;
        end
    end

endmodule

// ==== rtl/cfgreg.sv ====
`timescale 1ns/1ps

module cfgreg import apb_pkg::*, sysctl_pkg::*; #(
    parameter logic [XLEN-1:0] BOOTVEC_RESET = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  apb_req_t        req,
    output apb_rsp_t        rsp,
    output logic [XLEN-1:0] ddr_offset,
    output logic [XLEN-1:0] core_bootvec,
    output logic            core_rstn
);

    logic [REGION_BIT-1:0] offset;
    logic                  access;
    logic                  bad_addr;
    logic [XLEN-1:0]       cur_val;
    logic [XLEN-1:0]       wr_val;
    logic [XLEN-1:0]       ddr_offset_q;
    logic [XLEN-1:0]       bootvec_q;
    logic                  core_rst_q;

    assign offset = req.paddr[REGION_BIT-1:0];
    assign access = req.psel & req.penable;

    // read mux, also the base for strobe merging
    always_comb begin
        cur_val  = '0;
        bad_addr = 1'b0;
        case (offset)
            CFG_DDR_OFFSET: cur_val = ddr_offset_q;
            CFG_BOOTVEC:    cur_val = bootvec_q;
            CFG_CORE_RST:   cur_val = {{(XLEN-1){1'b0}}, core_rst_q};
            default:        bad_addr = 1'b1;
        endcase
    end

    assign wr_val = apply_strb(cur_val, req.pwdata, req.pstrb);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ddr_offset_q <= DDR_OFFSET_INIT;
            bootvec_q    <= BOOTVEC_RESET;
            core_rst_q   <= CORE_RSTN_INIT;
        end else if (access && req.pwrite && !bad_addr) begin
            case (offset)
                CFG_DDR_OFFSET: ddr_offset_q <= wr_val;
                CFG_BOOTVEC:    bootvec_q    <= wr_val;
                CFG_CORE_RST:   core_rst_q   <= wr_val[0];
                default:        ;
            endcase
        end
    end

    // zero wait states
    always_comb begin
        rsp.pready  = access;
        rsp.pslverr = access & bad_addr;
        rsp.prdata  = (access && !req.pwrite) ? cur_val : '0;
    end

    assign ddr_offset   = ddr_offset_q;
    assign core_bootvec = bootvec_q;
    assign core_rstn    = core_rst_q;

endmodule

// ==== rtl/rst_gen.sv ====
`timescale 1ns/1ps

module rst_gen #(
    parameter int RST_HOLD = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic core_rstn,
    input  logic warm_rst_trigger,
    output logic xrstn,
    output logic srstn
);

    localparam int CNT_W = $clog2(RST_HOLD + 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] hold_cnt;
    logic             cause;

    // two-flop synchronizer on the software core reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], core_rstn};
        end
    end

    assign xrstn = sync_q[1];
    assign cause = ~xrstn | warm_rst_trigger;

    // reload while a cause is present, then count down to release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= CNT_W'(RST_HOLD);
        end else if (cause) begin
            hold_cnt <= CNT_W'(RST_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign srstn = ~cause & (hold_cnt == '0);

endmodule

// ==== rtl/intc.sv ====
`timescale 1ns/1ps

module intc import apb_pkg::*, sysctl_pkg::*; #(
    parameter int NUM_INTS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              srstn,
    input  apb_req_t          req,
    output apb_rsp_t          rsp,
    input  logic [NUM_INTS-1:0] ints,
    output irq_t              irq,
    output logic [TIME_W-1:0] systime
);

    logic [REGION_BIT-1:0] offset;
    logic                  access;
    logic                  bad_addr;
    logic                  read_only;
    logic                  wr_err;
    logic [XLEN-1:0]       cur_val;
    logic [XLEN-1:0]       wr_val;
    logic [TIME_W-1:0]     mtime_q;
    logic [TIME_W-1:0]     mtimecmp_q;
    logic [NUM_INTS-1:0]   ie_q;
    logic                  msip_q;

    assign offset = req.paddr[REGION_BIT-1:0];
    assign access = req.psel & req.penable;

    // free-running system time, survives soft resets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_comb begin
        cur_val   = '0;
        bad_addr  = 1'b0;
        read_only = 1'b0;
        case (offset)
            INTC_MSIP:        cur_val = {{(XLEN-1){1'b0}}, msip_q};
            INTC_MTIMECMP_LO: cur_val = mtimecmp_q[XLEN-1:0];
            INTC_MTIMECMP_HI: cur_val = mtimecmp_q[TIME_W-1:XLEN];
            INTC_IE:          cur_val = XLEN'(ie_q);
            INTC_MTIME_LO: begin
                cur_val   = mtime_q[XLEN-1:0];
                read_only = 1'b1;
            end
            INTC_MTIME_HI: begin
                cur_val   = mtime_q[TIME_W-1:XLEN];
                read_only = 1'b1;
            end
            INTC_IP: begin
                // raw line levels, not masked by ie
                cur_val   = XLEN'(ints);
                read_only = 1'b1;
            end
            default: bad_addr = 1'b1;
        endcase
    end

    assign wr_err = bad_addr | (req.pwrite & read_only);
    assign wr_val = apply_strb(cur_val, req.pwdata, req.pstrb);

    // control registers live in the system reset domain
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            msip_q     <= 1'b0;
            mtimecmp_q <= MTIMECMP_INIT;
            ie_q       <= '0;
        end else if (access && req.pwrite && !wr_err) begin
            case (offset)
                INTC_MSIP:        msip_q                     <= wr_val[0];
                INTC_MTIMECMP_LO: mtimecmp_q[XLEN-1:0]       <= wr_val;
                INTC_MTIMECMP_HI: mtimecmp_q[TIME_W-1:XLEN]  <= wr_val;
                INTC_IE:          ie_q                       <= wr_val[NUM_INTS-1:0];
                default:          ;
            endcase
        end
    end

    always_comb begin
        rsp.pready  = access;
        rsp.pslverr = access & wr_err;
        rsp.prdata  = (access && !req.pwrite) ? cur_val : '0;
    end

    always_comb begin
        irq.msip = msip_q;
        irq.mtip = (mtime_q >= mtimecmp_q);
        irq.meip = |(ints & ie_q);
    end

    assign systime = mtime_q;

endmodule

// ==== rtl/sysctl_top.sv ====
`timescale 1ns/1ps

module sysctl_top import apb_pkg::*, sysctl_pkg::*; #(
    parameter logic [XLEN-1:0] BOOTVEC_RESET = '0,
    parameter int              RST_HOLD      = 4,
    parameter int              NUM_INTS      = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_req_t            apb_req,
    output apb_rsp_t            apb_rsp,
    input  logic                warm_rst_trigger,
    input  logic [NUM_INTS-1:0] ints,
    output logic [XLEN-1:0]     ddr_offset,
    output logic [XLEN-1:0]     core_bootvec,
    output logic                xrstn,
    output logic                srstn,
    output irq_t                irq,
    output logic [TIME_W-1:0]   systime
);

    apb_req_t cfg_req;
    apb_rsp_t cfg_rsp;
    apb_req_t intc_req;
    apb_rsp_t intc_rsp;
    logic     core_rstn;

    apb_split u_apb_split (
        .req      ( apb_req  ),
        .rsp      ( apb_rsp  ),
        .cfg_req  ( cfg_req  ),
        .cfg_rsp  ( cfg_rsp  ),
        .intc_req ( intc_req ),
        .intc_rsp ( intc_rsp )
    );

    cfgreg #(
        .BOOTVEC_RESET ( BOOTVEC_RESET )
    ) u_cfgreg (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .req          ( cfg_req      ),
        .rsp          ( cfg_rsp      ),
        .ddr_offset   ( ddr_offset   ),
        .core_bootvec ( core_bootvec ),
        .core_rstn    ( core_rstn    )
    );

    rst_gen #(
        .RST_HOLD ( RST_HOLD )
    ) u_rst_gen (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .core_rstn        ( core_rstn        ),
        .warm_rst_trigger ( warm_rst_trigger ),
        .xrstn            ( xrstn            ),
        .srstn            ( srstn            )
    );

    intc #(
        .NUM_INTS ( NUM_INTS )
    ) u_intc (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .srstn   ( srstn    ),
        .req     ( intc_req ),
        .rsp     ( intc_rsp ),
        .ints    ( ints     ),
        .irq     ( irq      ),
        .systime ( systime  )
    );

endmodule

// ==== verif/sysctl_props.sv ====
`timescale 1ns/1ps

module sysctl_props import apb_pkg::*, sysctl_pkg::*; #(
    parameter int RST_HOLD = 4,
    parameter int NUM_INTS = 2
) (
    input logic                clk,
    input logic                rst_n,
    input apb_req_t            apb_req,
    input apb_rsp_t            apb_rsp,
    input logic                xrstn,
    input logic                srstn,
    input irq_t                irq,
    input logic [TIME_W-1:0]   systime,
    input logic [NUM_INTS-1:0] ints
);

    int                    fail_cnt = 0;
    logic                  intc_wr;
    logic [REGION_BIT-1:0] wr_off;
    logic [TIME_W-1:0]     cmp_model;
    logic [NUM_INTS-1:0]   ie_model;

    // write access phase that lands in the intc region
    assign intc_wr = apb_req.psel && apb_req.penable && apb_req.pwrite
                     && (apb_req.paddr[APB_AW-1:REGION_BIT] == 'd1);
    assign wr_off  = apb_req.paddr[REGION_BIT-1:0];

    // compare and enable values as software wrote them
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            cmp_model <= '1;
            ie_model  <= '0;
        end else if (intc_wr) begin
            for (int b = 0; b < XLEN / 8; b++) begin
                if (apb_req.pstrb[b] && wr_off == INTC_MTIMECMP_LO) begin
                    cmp_model[b*8 +: 8] <= apb_req.pwdata[b*8 +: 8];
                end
                if (apb_req.pstrb[b] && wr_off == INTC_MTIMECMP_HI) begin
                    cmp_model[XLEN + b*8 +: 8] <= apb_req.pwdata[b*8 +: 8];
                end
            end
            if (apb_req.pstrb[0] && wr_off == INTC_IE) begin
                ie_model <= apb_req.pwdata[NUM_INTS-1:0];
            end
        end
    end

    // zero wait states on every access phase
    pready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
    ) else begin
        $error("access phase without pready");
        fail_cnt++;
    end

    // srstn high needs xrstn high now and RST_HOLD cycles back
    srstn_follows_xrstn: assert property (
        @(posedge clk) disable iff (!rst_n)
        srstn |-> (xrstn && $past(xrstn, RST_HOLD))
    ) else begin
        $error("srstn high while xrstn low or released too early");
        fail_cnt++;
    end

    mtip_rule: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq.mtip == (systime >= cmp_model)
    ) else begin
        $error("mtip does not match systime >= mtimecmp");
        fail_cnt++;
    end

    // external interrupt is the masked OR of the lines
    meip_rule: assert property (
        @(posedge clk) disable iff (!rst_n)
        irq.meip == |(ints & ie_model)
    ) else begin
        $error("meip does not match ints masked by ie");
        fail_cnt++;
    end

endmodule

bind sysctl_top sysctl_props #(
    .RST_HOLD ( RST_HOLD ),
    .NUM_INTS ( NUM_INTS )
) u_props (
    .clk      ( clk     ),
    .rst_n    ( rst_n   ),
    .apb_req  ( apb_req ),
    .apb_rsp  ( apb_rsp ),
    .xrstn    ( xrstn   ),
    .srstn    ( srstn   ),
    .irq      ( irq     ),
    .systime  ( systime ),
    .ints     ( ints    )
);

// ==== verif/sysctl_tb.sv ====
`timescale 1ns/1ps

module sysctl_tb import apb_pkg::*, sysctl_pkg::*;;

    localparam logic [31:0] BOOTVEC_RESET = 32'h0;
    localparam int          RST_HOLD      = 4;
    localparam int          NUM_INTS      = 2;
    localparam int          RST_CYCLES    = 5;
    // about 60 accesses of 3 cycles, reset waits and a 40 cycle timer wait, with margin
    localparam int          TIMEOUT_CYCLES = 2000;

    logic                clk;
    logic                rst_n;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic                warm_rst_trigger;
    logic [NUM_INTS-1:0] ints;
    logic [XLEN-1:0]     ddr_offset;
    logic [XLEN-1:0]     core_bootvec;
    logic                xrstn;
    logic                srstn;
    irq_t                irq;
    logic [TIME_W-1:0]   systime;

    int          val_errs = 0;
    int          proto_errs = 0;
    int          prop_errs;
    int          cycle_cnt = 0;
    int          sample_cycle;
    int          seed;
    int          n;
    int          c1;
    logic [31:0] rdata;
    logic [31:0] err;
    logic [31:0] wdata;
    logic [31:0] exp_ddr;
    logic [31:0] exp_boot;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [3:0]  strb;

    sysctl_top UUT (
        .clk              ( clk              ),
        .rst_n            ( rst_n            ),
        .apb_req          ( apb_req          ),
        .apb_rsp          ( apb_rsp          ),
        .warm_rst_trigger ( warm_rst_trigger ),
        .ints             ( ints             ),
        .ddr_offset       ( ddr_offset       ),
        .core_bootvec     ( core_bootvec     ),
        .xrstn            ( xrstn            ),
        .srstn            ( srstn            ),
        .irq              ( irq              ),
        .systime          ( systime          )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] cfg_addr(logic [REGION_BIT-1:0] off);
        return {20'h0, off};
    endfunction

    function automatic logic [31:0] intc_addr(logic [REGION_BIT-1:0] off);
        return {19'h0, 1'b1, off};
    endfunction

    // expected value after a strobed write
    function automatic logic [31:0] merge_bytes(logic [31:0] old_val, logic [31:0] new_val,
                                                logic [3:0] be);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = be[b] ? new_val[b*8 +: 8] : old_val[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic void check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            val_errs++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endfunction

    // setup phase, then access phase sampled at the falling edge
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wd,
                            input logic [3:0] be, output logic [31:0] rd,
                            output logic [31:0] slverr);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= wr;
        apb_req.pstrb   <= be;
        apb_req.pwdata  <= wd;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready) begin
            proto_errs++;
            $display("no pready from the slave at address %h", addr);
        end
        rd           = apb_rsp.prdata;
        slverr       = 32'(apb_rsp.pslverr);
        sample_cycle = cycle_cnt;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic reg_write(string name, logic [31:0] addr, logic [31:0] wd, logic [3:0] be);
        logic [31:0] rd;
        logic [31:0] slverr;
        apb_xfer(1'b1, addr, wd, be, rd, slverr);
        check_val(name, 32'd0, slverr);
    endtask

    task automatic reg_read(string name, logic [31:0] addr, logic [31:0] exp);
        logic [31:0] rd;
        logic [31:0] slverr;
        apb_xfer(1'b0, addr, 32'd0, 4'h0, rd, slverr);
        check_val({name, "_err"}, 32'd0, slverr);
        check_val(name, exp, rd);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n            = 1'b0;
        apb_req          = '0;
        warm_rst_trigger = 1'b0;
        ints             = '0;
        seed             = 17408;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        n = 0;
        while (!srstn && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_val("srstn_after_reset", 32'd1, 32'(srstn));

        // reset values and strobed writes
        reg_read("ddr_offset_init", cfg_addr(CFG_DDR_OFFSET), 32'h0);
        reg_read("bootvec_init", cfg_addr(CFG_BOOTVEC), BOOTVEC_RESET);
        reg_read("core_rst_init", cfg_addr(CFG_CORE_RST), 32'h1);
        exp_ddr  = 32'h0;
        exp_boot = BOOTVEC_RESET;
        for (int i = 0; i < 6; i++) begin
            wdata   = $random(seed);
            strb    = (i == 0) ? 4'hf : 4'($random(seed));
            exp_ddr = merge_bytes(exp_ddr, wdata, strb);
            reg_write("ddr_offset_wr", cfg_addr(CFG_DDR_OFFSET), wdata, strb);
            wdata    = $random(seed);
            exp_boot = merge_bytes(exp_boot, wdata, ~strb);
            reg_write("bootvec_wr", cfg_addr(CFG_BOOTVEC), wdata, ~strb);
            reg_read("ddr_offset_rd", cfg_addr(CFG_DDR_OFFSET), exp_ddr);
            reg_read("bootvec_rd", cfg_addr(CFG_BOOTVEC), exp_boot);
            @(negedge clk);
            check_val("ddr_offset_out", exp_ddr, ddr_offset);
            check_val("bootvec_out", exp_boot, core_bootvec);
        end

        // error responses leave registers alone
        apb_xfer(1'b1, 32'h0000_2000, 32'hdead_beef, 4'hf, rdata, err);
        check_val("out_of_map_wr_err", 32'd1, err);
        apb_xfer(1'b0, 32'h0000_2004, 32'd0, 4'h0, rdata, err);
        check_val("out_of_map_rd_err", 32'd1, err);
        check_val("out_of_map_rd_data", 32'd0, rdata);
        apb_xfer(1'b1, cfg_addr(12'h00C), 32'hffff_ffff, 4'hf, rdata, err);
        check_val("cfg_unmapped_err", 32'd1, err);
        apb_xfer(1'b0, intc_addr(12'h004), 32'd0, 4'h0, rdata, err);
        check_val("intc_unmapped_err", 32'd1, err);
        apb_xfer(1'b1, intc_addr(INTC_MTIME_LO), 32'd0, 4'hf, rdata, err);
        check_val("mtime_lo_wr_err", 32'd1, err);
        reg_read("ddr_offset_kept", cfg_addr(CFG_DDR_OFFSET), exp_ddr);
        reg_read("bootvec_kept", cfg_addr(CFG_BOOTVEC), exp_boot);

        // software core reset through the synchronizer
        reg_write("core_rst_clr", cfg_addr(CFG_CORE_RST), 32'd0, 4'hf);
        n = 0;
        @(negedge clk);
        while (xrstn && n < 3) begin
            @(negedge clk);
            n++;
        end
        check_val("core_rst_xrstn_low", 32'd0, 32'(xrstn));
        check_val("core_rst_srstn_low", 32'd0, 32'(srstn));
        reg_write("core_rst_set", cfg_addr(CFG_CORE_RST), 32'd1, 4'hf);
        n = 0;
        @(negedge clk);
        while (!xrstn && n < 3) begin
            @(negedge clk);
            n++;
        end
        check_val("core_rst_xrstn_high", 32'd1, 32'(xrstn));
        check_val("srstn_after_xrstn", 32'd0, 32'(srstn));
        n = 0;
        while (!srstn && n < RST_HOLD + 2) begin
            @(negedge clk);
            n++;
        end
        check_val("core_rst_srstn_high", 32'd1, 32'(srstn));

        // warm reset pulse hits srstn only
        @(posedge clk);
        warm_rst_trigger <= 1'b1;
        @(negedge clk);
        check_val("warm_srstn_low", 32'd0, 32'(srstn));
        check_val("warm_xrstn_kept", 32'd1, 32'(xrstn));
        @(posedge clk);
        warm_rst_trigger <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!srstn && n < 20) begin
            n++;
            @(negedge clk);
        end
        assert (n >= RST_HOLD) else begin
            val_errs++;
            $display("ERR warm_hold expected >= %0d actual %0d", RST_HOLD, n);
        end
        check_val("warm_srstn_release", 32'd1, 32'(srstn));

        // system time and timer compare
        apb_xfer(1'b0, intc_addr(INTC_MTIME_LO), 32'd0, 4'h0, t1, err);
        c1 = sample_cycle;
        repeat (7) @(posedge clk);
        apb_xfer(1'b0, intc_addr(INTC_MTIME_LO), 32'd0, 4'h0, t2, err);
        check_val("mtime_delta", 32'(sample_cycle - c1), t2 - t1);
        @(negedge clk);
        // counting starts at the first edge after reset release
        check_val("systime_lo", 32'(cycle_cnt - RST_CYCLES), systime[31:0]);
        check_val("systime_hi", 32'd0, systime[63:32]);
        reg_read("mtime_hi", intc_addr(INTC_MTIME_HI), 32'd0);
        reg_write("mtimecmp_hi_wr", intc_addr(INTC_MTIMECMP_HI), 32'd0, 4'hf);
        reg_write("mtimecmp_lo_wr", intc_addr(INTC_MTIMECMP_LO), t2 + 32'd40, 4'hf);
        @(negedge clk);
        check_val("mtip_before", 32'd0, 32'(irq.mtip));
        n = 0;
        while (!irq.mtip && n < 100) begin
            @(negedge clk);
            n++;
        end
        check_val("mtip_rise", 32'd1, 32'(irq.mtip));

        // external and software interrupts
        reg_write("ie_wr", intc_addr(INTC_IE), 32'h1, 4'hf);
        reg_read("ie_rd", intc_addr(INTC_IE), 32'h1);
        @(posedge clk);
        ints <= 2'b10;
        @(negedge clk);
        check_val("meip_masked", 32'd0, 32'(irq.meip));
        reg_read("ip_rd_line1", intc_addr(INTC_IP), 32'h2);
        @(posedge clk);
        ints <= 2'b01;
        @(negedge clk);
        check_val("meip_enabled", 32'd1, 32'(irq.meip));
        reg_read("ip_rd_line0", intc_addr(INTC_IP), 32'h1);
        reg_write("msip_set", intc_addr(INTC_MSIP), 32'h1, 4'hf);
        @(negedge clk);
        check_val("msip_high", 32'd1, 32'(irq.msip));
        reg_write("msip_clr", intc_addr(INTC_MSIP), 32'h0, 4'hf);
        @(negedge clk);
        check_val("msip_low", 32'd0, 32'(irq.msip));

        repeat (4) @(posedge clk);
        prop_errs = UUT.u_props.fail_cnt;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 val_errs, proto_errs, prop_errs);
        if (val_errs + proto_errs + prop_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sysctl.f ====
rtl/apb_pkg.sv
rtl/sysctl_pkg.sv
rtl/apb_split.sv
rtl/cfgreg.sv
rtl/rst_gen.sv
rtl/intc.sv
rtl/sysctl_top.sv
verif/sysctl_props.sv
verif/sysctl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sysctl_tb -f sysctl.f \
    && ./obj_dir/Vsysctl_tb +verilator+error+limit+100 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }
if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
